// File: axil_wr_subsys.f
design/axi_chan_pkg.sv
design/reg_map_pkg.sv
design/axi4_to_axil_wr.sv
design/axil_wr_arbiter.sv
design/axil_reg_bank.sv
design/axil_wr_subsys.sv
verif/tb_axil_wr_subsys.sv

// File: design/axi4_to_axil_wr.sv
// AXI4 write burst to AXI4-Lite converter
// One Lite write per beat and a single merged burst response back to the master

`timescale 1ns/10ps

module axi4_to_axil_wr (
    input  logic                   aclk,
    input  logic                   aresetn,
    // AXI4 slave side
    input  axi_chan_pkg::axi_aw_t  s_aw,
    input  logic                   s_aw_valid,
    output logic                   s_aw_ready,
    input  axi_chan_pkg::axi_w_t   s_w,
    input  logic                   s_w_valid,
    output logic                   s_w_ready,
    output axi_chan_pkg::axi_b_t   s_b,
    output logic                   s_b_valid,
    input  logic                   s_b_ready,
    // AXI4-Lite master side
    output axi_chan_pkg::axil_aw_t m_aw,
    output logic                   m_aw_valid,
    input  logic                   m_aw_ready,
    output axi_chan_pkg::axil_w_t  m_w,
    output logic                   m_w_valid,
    input  logic                   m_w_ready,
    input  axi_chan_pkg::axil_b_t  m_b,
    input  logic                   m_b_valid,
    output logic                   m_b_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_beat,
        st_wait_resp,
        st_resp
    } state_e;

    state_e state;

    // Captured burst
    logic [axi_chan_pkg::id_w-1:0]   burst_id;
    logic [axi_chan_pkg::addr_w-1:0] beat_addr;
    logic [7:0]                      burst_len;
    logic [2:0]                      burst_size;
    axi_chan_pkg::burst_e            burst_type;
    logic [2:0]                      burst_prot;
    axi_chan_pkg::resp_e             worst_resp;

    // Progress counters and per-beat flags
    logic [7:0] beat_cnt;
    logic [7:0] resp_cnt;
    logic       aw_done;
    logic       w_done;

    logic aw_accept;
    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic beat_end;

    // Address step unit
    logic [axi_chan_pkg::addr_w-1:0] step;
    logic [axi_chan_pkg::addr_w-1:0] len_ext;
    logic [axi_chan_pkg::addr_w-1:0] wrap_mask;
    logic [axi_chan_pkg::addr_w-1:0] incr_addr;
    logic [axi_chan_pkg::addr_w-1:0] next_addr;

    // ======================================================================
    // Handshakes
    // ======================================================================
    assign s_aw_ready = (state == st_idle);
    assign aw_accept  = s_aw_valid && s_aw_ready;

    // Lite AW and W are offered together for each beat
    assign m_aw       = '{addr: beat_addr, prot: burst_prot};
    assign m_aw_valid = (state == st_beat) && !aw_done;
    assign m_w        = '{data: s_w.data, strb: s_w.strb};
    assign m_w_valid  = (state == st_beat) && !w_done && s_w_valid;

    // AXI4 W is consumed exactly when the Lite W moves
    assign s_w_ready = (state == st_beat) && !w_done && m_w_ready;

    assign aw_fire  = m_aw_valid && m_aw_ready;
    assign w_fire   = m_w_valid && m_w_ready;
    assign beat_end = (aw_done || aw_fire) && (w_done || w_fire);

    // Lite responses may trail the beats still being issued
    assign m_b_ready = (state == st_beat) || (state == st_wait_resp);
    assign b_fire    = m_b_valid && m_b_ready;

    assign s_b       = '{id: burst_id, resp: worst_resp};
    assign s_b_valid = (state == st_resp);

    // ======================================================================
    // Address step
    // ======================================================================
    assign step      = {{(axi_chan_pkg::addr_w-1){1'b0}}, 1'b1} << burst_size;
    assign len_ext   = {{(axi_chan_pkg::addr_w-8){1'b0}}, burst_len};
    // Wrap window of (len+1) beats is always a power of two for WRAP
    assign wrap_mask = ((len_ext + 1'b1) << burst_size) - 1'b1;
    assign incr_addr = beat_addr + step;

    always_comb begin
        case (burst_type)
            axi_chan_pkg::burst_fixed: next_addr = beat_addr;
            axi_chan_pkg::burst_wrap:  next_addr = (beat_addr & ~wrap_mask) |
                                                   (incr_addr & wrap_mask);
            default:                   next_addr = incr_addr;
        endcase
    end

    // ======================================================================
    // Control state
    // ======================================================================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= st_idle;
            beat_cnt <= '0;
            resp_cnt <= '0;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (aw_accept) begin
                        state    <= st_beat;
                        beat_cnt <= '0;
                        resp_cnt <= '0;
                    end
                end
                st_beat: begin
                    if (beat_end) begin
                        aw_done  <= 1'b0;
                        w_done   <= 1'b0;
                        beat_cnt <= beat_cnt + 8'd1;
                        // Last beat issued
                        if (beat_cnt == burst_len) begin
                            state <= st_wait_resp;
                        end
                    end else begin
                        if (aw_fire) begin
                            aw_done <= 1'b1;
                        end
                        if (w_fire) begin
                            w_done <= 1'b1;
                        end
                    end
                end
                st_wait_resp: begin
                    if (b_fire && resp_cnt == burst_len) begin
                        state <= st_resp;
                    end
                end
                default: begin
                    if (s_b_ready) begin
                        state <= st_idle;
                    end
                end
            endcase
            if (b_fire) begin
                resp_cnt <= resp_cnt + 8'd1;
            end
        end
    end

    // ======================================================================
    // Burst payload and response merge
    // ======================================================================
    always_ff @(posedge aclk) begin
        if (aw_accept) begin
            burst_id   <= s_aw.id;
            beat_addr  <= s_aw.addr;
            burst_len  <= s_aw.len;
            burst_size <= s_aw.size;
            burst_type <= s_aw.burst;
            burst_prot <= s_aw.prot;
            worst_resp <= axi_chan_pkg::resp_okay;
        end else begin
            if (beat_end) begin
                beat_addr <= next_addr;
            end
            // Keep the worst code seen in this burst
            if (b_fire && m_b.resp > worst_resp) begin
                worst_resp <= m_b.resp;
            end
        end
    end

endmodule

// File: design/axi_chan_pkg.sv
// AXI4 and AXI4-Lite write channel definitions
// Shared payload structs, widths and protocol encodings

package axi_chan_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int id_w   = 4;
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // ======================================================================
    // Encodings
    // ======================================================================
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } burst_e;

    // Larger code ranks as the worse response
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_e;

    // ======================================================================
    // AXI4 full channels
    // ======================================================================
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        burst_e            burst;
        logic [2:0]        prot;
    } axi_aw_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        resp_e           resp;
    } axi_b_t;

    // ======================================================================
    // AXI4-Lite channels
    // ======================================================================
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axil_aw_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        resp_e resp;
    } axil_b_t;

endpackage

// File: design/axil_reg_bank.sv
// AXI4-Lite write slave with sixteen byte-strobed control registers

`timescale 1ns/10ps

module axil_reg_bank (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  axi_chan_pkg::axil_aw_t  s_aw,
    input  logic                    s_aw_valid,
    output logic                    s_aw_ready,
    input  axi_chan_pkg::axil_w_t   s_w,
    input  logic                    s_w_valid,
    output logic                    s_w_ready,
    output axi_chan_pkg::axil_b_t   s_b,
    output logic                    s_b_valid,
    input  logic                    s_b_ready,
    output reg_map_pkg::reg_array_t ctrl_regs
);

    logic                          pending;
    axi_chan_pkg::resp_e           resp_code;
    logic                          wr_fire;
    logic                          in_range;
    logic [reg_map_pkg::reg_idx_w-1:0] reg_idx;

    // AW and W only taken as a pair while idle
    assign s_aw_ready = !pending && s_w_valid;
    assign s_w_ready  = !pending && s_aw_valid;
    assign wr_fire    = s_aw_valid && s_w_valid && !pending;

    // Address decode
    assign in_range = (s_aw.addr < reg_map_pkg::reg_space_bytes);
    assign reg_idx  = s_aw.addr[reg_map_pkg::reg_addr_lsb +: reg_map_pkg::reg_idx_w];

    assign s_b       = '{resp: resp_code};
    assign s_b_valid = pending;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pending   <= 1'b0;
            resp_code <= axi_chan_pkg::resp_okay;
            ctrl_regs <= '0;
        end else if (wr_fire) begin
            pending   <= 1'b1;
            resp_code <= in_range ? axi_chan_pkg::resp_okay : axi_chan_pkg::resp_slverr;
            // Only strobed bytes of an in-range register change
            if (in_range) begin
                for (int b = 0; b < axi_chan_pkg::strb_w; b++) begin
                    if (s_w.strb[b]) begin
                        ctrl_regs[reg_idx][8*b +: 8] <= s_w.data[8*b +: 8];
                    end
                end
            end
        end else if (s_b_ready) begin
            pending <= 1'b0;
        end
    end

endmodule

// File: design/axil_wr_arbiter.sv
// Two-client AXI4-Lite write arbiter
// Round-robin grant held from the write until its response returns

`timescale 1ns/10ps

module axil_wr_arbiter (
    input  logic                   aclk,
    input  logic                   aresetn,
    // Client ports
    input  axi_chan_pkg::axil_aw_t c_aw [2],
    input  logic [1:0]             c_aw_valid,
    output logic [1:0]             c_aw_ready,
    input  axi_chan_pkg::axil_w_t  c_w [2],
    input  logic [1:0]             c_w_valid,
    output logic [1:0]             c_w_ready,
    output axi_chan_pkg::axil_b_t  c_b [2],
    output logic [1:0]             c_b_valid,
    input  logic [1:0]             c_b_ready,
    // Shared bus
    output axi_chan_pkg::axil_aw_t m_aw,
    output logic                   m_aw_valid,
    input  logic                   m_aw_ready,
    output axi_chan_pkg::axil_w_t  m_w,
    output logic                   m_w_valid,
    input  logic                   m_w_ready,
    input  axi_chan_pkg::axil_b_t  m_b,
    input  logic                   m_b_valid,
    output logic                   m_b_ready
);

    // Grant state
    logic busy;
    logic gnt_idx;
    logic rr_ptr;

    logic pick;
    logic sel;
    logic active;

    // ======================================================================
    // Selection
    // ======================================================================
    // Favoured client wins a tie and otherwise whoever is asking
    assign pick   = c_aw_valid[rr_ptr] ? rr_ptr : !rr_ptr;
    assign sel    = busy ? gnt_idx : pick;
    assign active = busy || (|c_aw_valid);

    // Granted client passes straight through without a register stage
    assign m_aw       = c_aw[sel];
    assign m_aw_valid = active && c_aw_valid[sel];
    assign m_w        = c_w[sel];
    assign m_w_valid  = active && c_w_valid[sel];
    assign m_b_ready  = busy && c_b_ready[gnt_idx];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            c_aw_ready[i] = active && (sel == i[0]) && m_aw_ready;
            c_w_ready[i]  = active && (sel == i[0]) && m_w_ready;
            c_b_valid[i]  = busy && (gnt_idx == i[0]) && m_b_valid;
            c_b[i]        = m_b;
        end
    end

    // ======================================================================
    // Grant tracking
    // ======================================================================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy    <= 1'b0;
            gnt_idx <= 1'b0;
            rr_ptr  <= 1'b0;
        end else if (!busy) begin
            // Lock on the first transfer of the chosen client
            if ((m_aw_valid && m_aw_ready) || (m_w_valid && m_w_ready)) begin
                busy    <= 1'b1;
                gnt_idx <= sel;
            end
        end else if (m_b_valid && m_b_ready) begin
            // Release and hand priority to the other client
            busy   <= 1'b0;
            rr_ptr <= !gnt_idx;
        end
    end

endmodule

// File: design/axil_wr_subsys.sv
// Control register subsystem
// Two AXI4 write ports, converted and arbitrated onto one register bank

`timescale 1ns/10ps

module axil_wr_subsys (
    input  logic                    aclk,
    input  logic                    aresetn,
    // AXI4 port 0
    input  axi_chan_pkg::axi_aw_t   s0_aw,
    input  logic                    s0_aw_valid,
    output logic                    s0_aw_ready,
    input  axi_chan_pkg::axi_w_t    s0_w,
    input  logic                    s0_w_valid,
    output logic                    s0_w_ready,
    output axi_chan_pkg::axi_b_t    s0_b,
    output logic                    s0_b_valid,
    input  logic                    s0_b_ready,
    // AXI4 port 1
    input  axi_chan_pkg::axi_aw_t   s1_aw,
    input  logic                    s1_aw_valid,
    output logic                    s1_aw_ready,
    input  axi_chan_pkg::axi_w_t    s1_w,
    input  logic                    s1_w_valid,
    output logic                    s1_w_ready,
    output axi_chan_pkg::axi_b_t    s1_b,
    output logic                    s1_b_valid,
    input  logic                    s1_b_ready,
    // Register contents
    output reg_map_pkg::reg_array_t ctrl_regs
);

    // Converter side of the arbiter
    axi_chan_pkg::axil_aw_t c_aw [2];
    axi_chan_pkg::axil_w_t  c_w [2];
    axi_chan_pkg::axil_b_t  c_b [2];
    logic [1:0]             c_aw_valid;
    logic [1:0]             c_aw_ready;
    logic [1:0]             c_w_valid;
    logic [1:0]             c_w_ready;
    logic [1:0]             c_b_valid;
    logic [1:0]             c_b_ready;

    // Shared Lite bus
    axi_chan_pkg::axil_aw_t bus_aw;
    axi_chan_pkg::axil_w_t  bus_w;
    axi_chan_pkg::axil_b_t  bus_b;
    logic                   bus_aw_valid;
    logic                   bus_aw_ready;
    logic                   bus_w_valid;
    logic                   bus_w_ready;
    logic                   bus_b_valid;
    logic                   bus_b_ready;

    // ======================================================================
    // Burst converters
    // ======================================================================
    axi4_to_axil_wr u_conv0 (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .s_aw       (s0_aw),
        .s_aw_valid (s0_aw_valid),
        .s_aw_ready (s0_aw_ready),
        .s_w        (s0_w),
        .s_w_valid  (s0_w_valid),
        .s_w_ready  (s0_w_ready),
        .s_b        (s0_b),
        .s_b_valid  (s0_b_valid),
        .s_b_ready  (s0_b_ready),
        .m_aw       (c_aw[0]),
        .m_aw_valid (c_aw_valid[0]),
        .m_aw_ready (c_aw_ready[0]),
        .m_w        (c_w[0]),
        .m_w_valid  (c_w_valid[0]),
        .m_w_ready  (c_w_ready[0]),
        .m_b        (c_b[0]),
        .m_b_valid  (c_b_valid[0]),
        .m_b_ready  (c_b_ready[0])
    );

    axi4_to_axil_wr u_conv1 (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .s_aw       (s1_aw),
        .s_aw_valid (s1_aw_valid),
        .s_aw_ready (s1_aw_ready),
        .s_w        (s1_w),
        .s_w_valid  (s1_w_valid),
        .s_w_ready  (s1_w_ready),
        .s_b        (s1_b),
        .s_b_valid  (s1_b_valid),
        .s_b_ready  (s1_b_ready),
        .m_aw       (c_aw[1]),
        .m_aw_valid (c_aw_valid[1]),
        .m_aw_ready (c_aw_ready[1]),
        .m_w        (c_w[1]),
        .m_w_valid  (c_w_valid[1]),
        .m_w_ready  (c_w_ready[1]),
        .m_b        (c_b[1]),
        .m_b_valid  (c_b_valid[1]),
        .m_b_ready  (c_b_ready[1])
    );

    // ======================================================================
    // Arbiter and register bank
    // ======================================================================
    axil_wr_arbiter u_arb (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .c_aw       (c_aw),
        .c_aw_valid (c_aw_valid),
        .c_aw_ready (c_aw_ready),
        .c_w        (c_w),
        .c_w_valid  (c_w_valid),
        .c_w_ready  (c_w_ready),
        .c_b        (c_b),
        .c_b_valid  (c_b_valid),
        .c_b_ready  (c_b_ready),
        .m_aw       (bus_aw),
        .m_aw_valid (bus_aw_valid),
        .m_aw_ready (bus_aw_ready),
        .m_w        (bus_w),
        .m_w_valid  (bus_w_valid),
        .m_w_ready  (bus_w_ready),
        .m_b        (bus_b),
        .m_b_valid  (bus_b_valid),
        .m_b_ready  (bus_b_ready)
    );

    axil_reg_bank u_bank (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .s_aw       (bus_aw),
        .s_aw_valid (bus_aw_valid),
        .s_aw_ready (bus_aw_ready),
        .s_w        (bus_w),
        .s_w_valid  (bus_w_valid),
        .s_w_ready  (bus_w_ready),
        .s_b        (bus_b),
        .s_b_valid  (bus_b_valid),
        .s_b_ready  (bus_b_ready),
        .ctrl_regs  (ctrl_regs)
    );

endmodule

// File: design/reg_map_pkg.sv
// Control register map
// Bank size and address decode constants

package reg_map_pkg;

    // Sixteen word registers
    localparam int reg_count = 16;
    localparam int reg_idx_w = 4;

    // Byte offset of the register index inside the address
    localparam int reg_addr_lsb = 2;

    // Addresses at or above this limit are out of range
    localparam int reg_space_bytes = reg_count * (axi_chan_pkg::data_w / 8);

    // Whole bank as one packed vector with register 0 in the low word
    typedef logic [reg_count-1:0][axi_chan_pkg::data_w-1:0] reg_array_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Builds the subsystem testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_axil_wr_subsys \
    -f axil_wr_subsys.f -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build did not complete"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -qx "Simulation PASSED" sim.log && echo "Run passed" || { echo "Run did not pass"; exit 1; }

// File: verif/tb_axil_wr_subsys.sv
// Testbench for the control register subsystem
// Drives AXI4 bursts on both ports and checks responses and ctrl_regs against a shadow model

`timescale 1ns/10ps

module tb_axil_wr_subsys;

    localparam int wait_limit = 200;

    logic aclk;
    logic aresetn;

    // Port signals with index 0 for s0 and index 1 for s1
    axi_chan_pkg::axi_aw_t   aw [2];
    logic [1:0]              aw_valid;
    logic [1:0]              aw_ready;
    axi_chan_pkg::axi_w_t    w [2];
    logic [1:0]              w_valid;
    logic [1:0]              w_ready;
    axi_chan_pkg::axi_b_t    b [2];
    logic [1:0]              b_valid;
    logic [1:0]              b_ready;
    reg_map_pkg::reg_array_t ctrl_regs;

    // Beat payloads per port, shadow registers, expected responses
    logic [31:0]             beat_data [2][256];
    logic [3:0]              beat_strb [2][256];
    reg_map_pkg::reg_array_t shadow;
    axi_chan_pkg::axi_b_t    exp_b [2];
    int                      b_count [2];
    logic                    bready_random;

    // Bookkeeping
    int    errors;
    int    checks;
    int    tests_run;
    int    tests_bad;
    int    test_err_start;
    string test_name;

    axil_wr_subsys u_axil_wr_subsys (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s0_aw       (aw[0]),
        .s0_aw_valid (aw_valid[0]),
        .s0_aw_ready (aw_ready[0]),
        .s0_w        (w[0]),
        .s0_w_valid  (w_valid[0]),
        .s0_w_ready  (w_ready[0]),
        .s0_b        (b[0]),
        .s0_b_valid  (b_valid[0]),
        .s0_b_ready  (b_ready[0]),
        .s1_aw       (aw[1]),
        .s1_aw_valid (aw_valid[1]),
        .s1_aw_ready (aw_ready[1]),
        .s1_w        (w[1]),
        .s1_w_valid  (w_valid[1]),
        .s1_w_ready  (w_ready[1]),
        .s1_b        (b[1]),
        .s1_b_valid  (b_valid[1]),
        .s1_b_ready  (b_ready[1]),
        .ctrl_regs   (ctrl_regs)
    );

    // 100 ns clock
    always #50 aclk = ~aclk;

    // Master side B ready that toggles at random for back-pressure when enabled
    always @(posedge aclk) begin
        if (bready_random) begin
            b_ready <= 2'($urandom);
        end else begin
            b_ready <= 2'b11;
        end
    end

    // ======================================================================
    // Reference model
    // ======================================================================
    // Address of beat n from the AXI4 burst rules
    function automatic logic [31:0] beat_addr(input axi_chan_pkg::axi_aw_t a, input int n);
        int unsigned nbytes;
        int unsigned win;
        int unsigned base;
        nbytes = 1 << a.size;
        case (a.burst)
            axi_chan_pkg::burst_fixed: return a.addr;
            axi_chan_pkg::burst_wrap: begin
                // Aligned window of (len+1) beats
                win  = (a.len + 1) * nbytes;
                base = (a.addr / win) * win;
                return base + ((a.addr - base + n * nbytes) % win);
            end
            default: return a.addr + n * nbytes;
        endcase
    endfunction

    // Applies a burst to the shadow array and gives the expected burst response
    function automatic axi_chan_pkg::resp_e model_burst(input int p,
                                                        input axi_chan_pkg::axi_aw_t a);
        axi_chan_pkg::resp_e worst;
        logic [31:0]         addr;
        worst = axi_chan_pkg::resp_okay;
        for (int n = 0; n <= int'(a.len); n++) begin
            addr = beat_addr(a, n);
            if (addr >= reg_map_pkg::reg_space_bytes) begin
                // Out of range beat writes nothing
                worst = axi_chan_pkg::resp_slverr;
            end else begin
                for (int k = 0; k < 4; k++) begin
                    if (beat_strb[p][n][k]) begin
                        shadow[addr[5:2]][8*k +: 8] = beat_data[p][n][8*k +: 8];
                    end
                end
            end
        end
        return worst;
    endfunction

    // ======================================================================
    // Checks
    // ======================================================================
    task automatic check_resp(input int p, input axi_chan_pkg::axi_b_t got,
                              input axi_chan_pkg::axi_b_t exp);
        checks++;
        if (got.id !== exp.id) begin
            errors++;
            $display("Fail time=%0t s%0d_b.id expected %h got %h", $time, p, exp.id, got.id);
        end
        if (got.resp !== exp.resp) begin
            errors++;
            $display("Fail time=%0t s%0d_b.resp expected %0d got %0d",
                     $time, p, exp.resp, got.resp);
        end
    endtask

    task automatic check_regs(input reg_map_pkg::reg_array_t got);
        for (int r = 0; r < reg_map_pkg::reg_count; r++) begin
            checks++;
            if (got[r] !== shadow[r]) begin
                errors++;
                $display("Fail time=%0t ctrl_regs[%0d] expected %h got %h",
                         $time, r, shadow[r], got[r]);
            end
        end
    endtask

    // Compares every burst response as it transfers to the master
    always @(negedge aclk) begin
        for (int p = 0; p < 2; p++) begin
            if (aresetn && b_valid[p] && b_ready[p]) begin
                check_resp(p, b[p], exp_b[p]);
                b_count[p]++;
            end
        end
    end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================
    function automatic axi_chan_pkg::axi_aw_t make_aw(input logic [3:0] id,
                                                      input logic [31:0] addr,
                                                      input logic [7:0] len,
                                                      input axi_chan_pkg::burst_e bt);
        return '{id: id, addr: addr, len: len, size: 3'd2, burst: bt, prot: 3'd0};
    endfunction

    task automatic set_beat(input int p, input int n, input logic [31:0] d,
                            input logic [3:0] s);
        beat_data[p][n] = d;
        beat_strb[p][n] = s;
    endtask

    task automatic give_up(input int p, input string what);
        errors++;
        $display("Timeout on port s%0d while waiting for %s", p, what);
        // Withdraw the port's valids on the next rising edge
        @(posedge aclk);
        aw_valid[p] <= 1'b0;
        w_valid[p]  <= 1'b0;
    endtask

    // Runs one full AXI4 burst on port p and returns once its response has transferred
    task automatic run_burst(input int p, input axi_chan_pkg::axi_aw_t a);
        int t;
        int start;
        exp_b[p] = '{id: a.id, resp: model_burst(p, a)};
        start    = b_count[p];
        @(posedge aclk);
        aw[p]       <= a;
        aw_valid[p] <= 1'b1;
        for (t = 0; t < wait_limit; t++) begin
            @(negedge aclk);
            if (aw_ready[p]) break;
        end
        if (t == wait_limit) begin
            give_up(p, "the address handshake");
            return;
        end
        @(posedge aclk);
        aw_valid[p] <= 1'b0;
        for (int n = 0; n <= int'(a.len); n++) begin
            w[p]       <= '{data: beat_data[p][n], strb: beat_strb[p][n], last: (n == a.len)};
            w_valid[p] <= 1'b1;
            for (t = 0; t < wait_limit; t++) begin
                @(negedge aclk);
                if (w_ready[p]) break;
            end
            if (t == wait_limit) begin
                give_up(p, "a data beat to be taken");
                return;
            end
            @(posedge aclk);
        end
        w_valid[p] <= 1'b0;
        // Response is counted by the compare process
        for (t = 0; t < wait_limit; t++) begin
            if (b_count[p] != start) break;
            @(posedge aclk);
        end
        if (t == wait_limit) begin
            give_up(p, "the burst response");
        end
    endtask

    // Random bursts kept inside this port's half of the bank
    task automatic random_traffic(input int p, input int count);
        axi_chan_pkg::burst_e bt;
        int unsigned          len;
        int unsigned          first;
        for (int i = 0; i < count; i++) begin
            case ($urandom % 3)
                0: begin
                    bt    = axi_chan_pkg::burst_fixed;
                    len   = $urandom % 4;
                    first = $urandom % 8;
                end
                1: begin
                    bt    = axi_chan_pkg::burst_incr;
                    len   = $urandom % 4;
                    first = $urandom % (8 - len);
                end
                default: begin
                    bt    = axi_chan_pkg::burst_wrap;
                    len   = ($urandom % 2 == 1) ? 3 : 1;
                    first = $urandom % 8;
                end
            endcase
            for (int n = 0; n <= int'(len); n++) begin
                set_beat(p, n, $urandom, 4'($urandom));
            end
            run_burst(p, make_aw(4'($urandom), 32'(p * 32 + first * 4), 8'(len), bt));
        end
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = errors;
        tests_run++;
    endtask

    task automatic close_test();
        @(negedge aclk);
        check_regs(ctrl_regs);
        if (errors == test_err_start) begin
            $display("Test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_bad++;
            $display("Test %0d %s: %0d errors", tests_run, test_name, errors - test_err_start);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        void'($urandom(37260));
        aclk          = 1'b0;
        aresetn       = 1'b0;
        aw[0]         = '0;
        aw[1]         = '0;
        w[0]          = '0;
        w[1]          = '0;
        aw_valid      = 2'b00;
        w_valid       = 2'b00;
        b_ready       = 2'b11;
        bready_random = 1'b0;
        shadow        = '0;
        b_count[0]    = 0;
        b_count[1]    = 0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_bad     = 0;
        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;

        start_test("single writes with strobes");
        set_beat(0, 0, 32'h1122_3344, 4'hf);
        run_burst(0, make_aw(4'h3, 32'h00, 8'd0, axi_chan_pkg::burst_incr));
        set_beat(0, 0, 32'haabb_ccdd, 4'b0101);
        run_burst(0, make_aw(4'h7, 32'h00, 8'd0, axi_chan_pkg::burst_incr));
        set_beat(0, 0, 32'hdead_beef, 4'b1000);
        run_burst(0, make_aw(4'h1, 32'h14, 8'd0, axi_chan_pkg::burst_incr));
        set_beat(0, 0, 32'h5a5a_5a5a, 4'b0010);
        run_burst(0, make_aw(4'hf, 32'h3c, 8'd0, axi_chan_pkg::burst_incr));
        close_test();

        start_test("incr burst of eight");
        for (int n = 0; n < 8; n++) begin
            set_beat(0, n, $urandom, 4'hf);
        end
        run_burst(0, make_aw(4'h5, 32'h10, 8'd7, axi_chan_pkg::burst_incr));
        close_test();

        // Each beat touches a different byte lane of one register
        start_test("fixed burst merge");
        set_beat(0, 0, 32'h0000_0011, 4'b0001);
        set_beat(0, 1, 32'h0000_2200, 4'b0010);
        set_beat(0, 2, 32'h0033_0000, 4'b0100);
        set_beat(0, 3, 32'h4400_0000, 4'b1000);
        run_burst(0, make_aw(4'h9, 32'h08, 8'd3, axi_chan_pkg::burst_fixed));
        close_test();

        // Starts at register 10 and wraps back to 8 inside the 16 byte window
        start_test("wrap burst mid window");
        for (int n = 0; n < 4; n++) begin
            set_beat(0, n, 32'hc0de_0000 + 32'(n), 4'hf);
        end
        run_burst(0, make_aw(4'hc, 32'h28, 8'd3, axi_chan_pkg::burst_wrap));
        close_test();

        // Last two beats fall past the register space
        start_test("incr burst past the bank");
        for (int n = 0; n < 4; n++) begin
            set_beat(0, n, $urandom, 4'hf);
        end
        run_burst(0, make_aw(4'he, 32'h38, 8'd3, axi_chan_pkg::burst_incr));
        close_test();

        start_test("random traffic on both ports");
        bready_random = 1'b1;
        fork
            random_traffic(0, 12);
            random_traffic(1, 12);
        join
        bready_random = 1'b0;
        close_test();

        $display("Tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
